// ==== logic/armIsaPkg.sv ====
package armIsaPkg;

  typedef logic [3:0] regIndex;

  // R15 reads as the PC and is never written
  localparam regIndex pcIndex = 4'd15;

  typedef enum logic [3:0] {
    condEq = 4'b0000,
    condNe = 4'b0001,
    condAl = 4'b1110
  } condCode;

  typedef enum logic [3:0] {
    opAnd = 4'b0000,
    opSub = 4'b0010,
    opAdd = 4'b0100,
    opCmp = 4'b1010,
    opOrr = 4'b1100,
    opMov = 4'b1101
  } dpOpcode;

  // Bits 27:26 of every instruction
  typedef enum logic [1:0] {
    classDp  = 2'b00,
    classMem = 2'b01,
    classBr  = 2'b10
  } instrClass;

  // Register form keeps Rm in imm8[3:0], shift bits ignored
  typedef struct packed {
    condCode    cond;
    instrClass  opClass;
    logic       immFlag;
    dpOpcode    opcode;
    logic       sBit;
    regIndex    rn;
    regIndex    rd;
    logic [3:0] rot;
    logic [7:0] imm8;
  } dpFields;

  typedef struct packed {
    condCode     cond;
    instrClass   opClass;
    logic        regOffset;
    logic        preIndex;
    logic        up;
    logic        byteSel;
    logic        writeBack;
    logic        load;
    regIndex     rn;
    regIndex     rd;
    logic [11:0] imm12;
  } memFields;

  typedef struct packed {
    condCode     cond;
    instrClass   opClass;
    logic [1:0]  brKind;
    logic [23:0] imm24;
  } brFields;

  typedef union packed {
    dpFields  dp;
    memFields mem;
    brFields  br;
  } instrWord;

endpackage

// ==== logic/pipeCtrlPkg.sv ====
package pipeCtrlPkg;

  typedef enum logic [1:0] {
    aluAdd = 2'b00,
    aluSub = 2'b01,
    aluAnd = 2'b10,
    aluOrr = 2'b11
  } aluOp;

  // Source of an execute operand
  typedef enum logic [1:0] {
    fwdReg = 2'b00,
    fwdWb  = 2'b01,
    fwdMem = 2'b10
  } fwdSel;

  // NZCV, N in the top bit
  typedef logic [3:0] flagSet;

  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

endpackage

// ==== logic/regFile.sv ====
`timescale 1ns/1ns

module regFile import armIsaPkg::*; (
  input  logic        clk,
  input  logic        we,
  input  regIndex     ra1,
  input  regIndex     ra2,
  input  regIndex     wa,
  input  logic [31:0] wd,
  input  logic [31:0] pcPlus8,
  output logic [31:0] rd1,
  output logic [31:0] rd2
);

  logic [31:0] regs [0:14];

  always_ff @(posedge clk) begin
    if (we && wa != pcIndex) begin
      regs[wa] <= wd;
    end
  end

  // A write in the same cycle is passed through, so decode sees it
  function automatic logic [31:0] readPort(regIndex ra);
    logic [31:0] value;
    if (ra == pcIndex) begin
      value = pcPlus8;
    end else if (we && ra == wa) begin
      value = wd;
    end else begin
      value = regs[ra];
    end
    return value;
  endfunction

  always_comb begin
    rd1 = readPort(ra1);
    rd2 = readPort(ra2);
  end

endmodule

// ==== logic/fetchDecode.sv ====
`timescale 1ns/1ns

module fetchDecode import armIsaPkg::*, pipeCtrlPkg::*; #(
  parameter logic [31:0] resetVector = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        rstN,
  input  logic        stallF,
  input  logic        stallD,
  input  logic        flushD,
  input  logic        branchTakenE,
  input  logic [31:0] branchTargetE,
  input  logic        regWriteW,
  input  regIndex     wa3W,
  input  logic [31:0] resultW,
  input  logic [31:0] instr,
  output logic [31:0] pc,
  output condCode     condD,
  output aluOp        aluOpD,
  output logic        aluSrcD,
  output logic        zeroAD,
  output logic        setFlagsD,
  output logic        regWriteD,
  output logic        memWriteD,
  output logic        memToRegD,
  output logic        branchD,
  output logic [31:0] rd1D,
  output logic [31:0] rd2D,
  output regIndex     ra1D,
  output regIndex     ra2D,
  output regIndex     wa3D,
  output logic [31:0] extImmD
);

  logic [31:0] pcPlus4;
  logic [31:0] pcNext;
  instrWord    instrD;
  logic        validD;
  logic [31:0] immBase;
  logic [4:0]  rotAmt;
  logic [31:0] immRot;

  // Fetch
  assign pcPlus4 = pc + 32'd4;
  assign pcNext  = branchTakenE ? branchTargetE : pcPlus4;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= resetVector;
    end else if (!stallF) begin
      pc <= pcNext;
    end
  end

  // Fetch/decode register, an empty slot is a bubble
  always_ff @(posedge clk) begin
    if (!rstN || flushD) begin
      validD <= 1'b0;
    end else if (!stallD) begin
      validD <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallD) begin
      instrD <= instr;
    end
  end

  // imm8 rotated right by twice the rotate field
  assign immBase = {24'd0, instrD.dp.imm8};
  assign rotAmt  = {instrD.dp.rot, 1'b0};
  assign immRot  = (immBase >> rotAmt) | (immBase << (6'd32 - {1'b0, rotAmt}));

  // Unused read ports point at R15 so they never raise a hazard
  always_comb begin
    condD     = instrD.dp.cond;
    aluOpD    = aluAdd;
    aluSrcD   = 1'b1;
    zeroAD    = 1'b0;
    setFlagsD = 1'b0;
    regWriteD = 1'b0;
    memWriteD = 1'b0;
    memToRegD = 1'b0;
    branchD   = 1'b0;
    ra1D      = pcIndex;
    ra2D      = pcIndex;
    wa3D      = instrD.dp.rd;
    extImmD   = immRot;
    case (instrD.dp.opClass)
      classDp: begin
        aluSrcD   = instrD.dp.immFlag;
        setFlagsD = validD & (instrD.dp.sBit | (instrD.dp.opcode == opCmp));
        regWriteD = validD;
        ra1D      = instrD.dp.rn;
        if (!instrD.dp.immFlag) begin
          ra2D = instrD.dp.imm8[3:0];
        end
        case (instrD.dp.opcode)
          opAdd: aluOpD = aluAdd;
          opSub: aluOpD = aluSub;
          opAnd: aluOpD = aluAnd;
          opOrr: aluOpD = aluOrr;
          opMov: begin
            // ORR with a zero first operand
            aluOpD = aluOrr;
            zeroAD = 1'b1;
            ra1D   = pcIndex;
          end
          opCmp: begin
            aluOpD    = aluSub;
            regWriteD = 1'b0;
          end
          default: begin
            regWriteD = 1'b0;
            setFlagsD = 1'b0;
          end
        endcase
      end
      classMem: begin
        aluOpD    = instrD.mem.up ? aluAdd : aluSub;
        ra1D      = instrD.mem.rn;
        ra2D      = instrD.mem.rd;
        wa3D      = instrD.mem.rd;
        extImmD   = {20'd0, instrD.mem.imm12};
        regWriteD = validD & instrD.mem.load;
        memToRegD = validD & instrD.mem.load;
        memWriteD = validD & ~instrD.mem.load;
      end
      classBr: begin
        // Target is PC+8 plus the word offset, added in execute
        extImmD = {{6{instrD.br.imm24[23]}}, instrD.br.imm24, 2'b00};
        branchD = validD;
      end
      default: begin
        extImmD = immRot;
      end
    endcase
  end

  regFile i_regFile (
    .clk,
    .we      (regWriteW),
    .ra1     (ra1D),
    .ra2     (ra2D),
    .wa      (wa3W),
    .wd      (resultW),
    .pcPlus8 (pcPlus4),
    .rd1     (rd1D),
    .rd2     (rd2D)
  );

endmodule

// ==== logic/executeStage.sv ====
`timescale 1ns/1ns

module executeStage import armIsaPkg::*, pipeCtrlPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic        flushE,
  input  fwdSel       forwardAE,
  input  fwdSel       forwardBE,
  input  condCode     condD,
  input  aluOp        aluOpD,
  input  logic        aluSrcD,
  input  logic        zeroAD,
  input  logic        setFlagsD,
  input  logic        regWriteD,
  input  logic        memWriteD,
  input  logic        memToRegD,
  input  logic        branchD,
  input  logic [31:0] rd1D,
  input  logic [31:0] rd2D,
  input  regIndex     ra1D,
  input  regIndex     ra2D,
  input  regIndex     wa3D,
  input  logic [31:0] extImmD,
  input  logic [31:0] resultW,
  output logic        branchTakenE,
  output logic [31:0] branchTargetE,
  output logic [31:0] aluOutM,
  output logic [31:0] writeDataM,
  output regIndex     wa3M,
  output logic        regWriteM,
  output logic        memWriteM,
  output logic        memToRegM,
  output regIndex     ra1E,
  output regIndex     ra2E,
  output regIndex     wa3E,
  output logic        memToRegE
);

  condCode     condE;
  aluOp        aluOpE;
  logic        aluSrcE;
  logic        zeroAE;
  logic        setFlagsE;
  logic        regWriteE;
  logic        memWriteE;
  logic        branchE;
  logic [31:0] rd1E;
  logic [31:0] rd2E;
  logic [31:0] extImmE;
  logic [31:0] srcAE;
  logic [31:0] srcBE;
  logic [31:0] bAddE;
  logic [31:0] writeDataE;
  logic [32:0] sumE;
  logic [31:0] aluResultE;
  flagSet      aluFlagsE;
  flagSet      flags;
  logic        condHoldsE;

  // Decode/execute register
  always_ff @(posedge clk) begin
    if (!rstN || flushE) begin
      setFlagsE <= 1'b0;
      regWriteE <= 1'b0;
      memWriteE <= 1'b0;
      memToRegE <= 1'b0;
      branchE   <= 1'b0;
    end else begin
      setFlagsE <= setFlagsD;
      regWriteE <= regWriteD;
      memWriteE <= memWriteD;
      memToRegE <= memToRegD;
      branchE   <= branchD;
    end
  end

  always_ff @(posedge clk) begin
    condE   <= condD;
    aluOpE  <= aluOpD;
    aluSrcE <= aluSrcD;
    zeroAE  <= zeroAD;
    rd1E    <= rd1D;
    rd2E    <= rd2D;
    extImmE <= extImmD;
    ra1E    <= ra1D;
    ra2E    <= ra2D;
    wa3E    <= wa3D;
  end

  function automatic logic [31:0] fwdMux(fwdSel sel, logic [31:0] regVal,
                                         logic [31:0] wbVal, logic [31:0] memVal);
    logic [31:0] value;
    case (sel)
      fwdWb:   value = wbVal;
      fwdMem:  value = memVal;
      default: value = regVal;
    endcase
    return value;
  endfunction

  assign srcAE      = zeroAE ? 32'd0 : fwdMux(forwardAE, rd1E, resultW, aluOutM);
  assign writeDataE = fwdMux(forwardBE, rd2E, resultW, aluOutM);
  assign srcBE      = aluSrcE ? extImmE : writeDataE;

  // One adder for both, subtract is A + ~B + 1
  assign bAddE = (aluOpE == aluSub) ? ~srcBE : srcBE;
  assign sumE  = {1'b0, srcAE} + {1'b0, bAddE} + {32'd0, aluOpE == aluSub};

  always_comb begin
    case (aluOpE)
      aluAnd:  aluResultE = srcAE & srcBE;
      aluOrr:  aluResultE = srcAE | srcBE;
      default: aluResultE = sumE[31:0];
    endcase
  end

  // Logical ops keep C and V
  always_comb begin
    aluFlagsE[flagN] = aluResultE[31];
    aluFlagsE[flagZ] = (aluResultE == 32'd0);
    aluFlagsE[flagC] = flags[flagC];
    aluFlagsE[flagV] = flags[flagV];
    if (aluOpE == aluAdd || aluOpE == aluSub) begin
      aluFlagsE[flagC] = sumE[32];
      aluFlagsE[flagV] = (srcAE[31] == bAddE[31]) && (sumE[31] != srcAE[31]);
    end
  end

  always_comb begin
    case (condE)
      condAl:  condHoldsE = 1'b1;
      condEq:  condHoldsE = flags[flagZ];
      condNe:  condHoldsE = !flags[flagZ];
      default: condHoldsE = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else if (setFlagsE && condHoldsE) begin
      flags <= aluFlagsE;
    end
  end

  assign branchTakenE  = branchE & condHoldsE;
  assign branchTargetE = aluResultE;

  // Execute/memory register, strobes only for a passing condition
  always_ff @(posedge clk) begin
    if (!rstN) begin
      regWriteM <= 1'b0;
      memWriteM <= 1'b0;
      memToRegM <= 1'b0;
    end else begin
      regWriteM <= regWriteE & condHoldsE;
      memWriteM <= memWriteE & condHoldsE;
      memToRegM <= memToRegE & condHoldsE;
    end
  end

  always_ff @(posedge clk) begin
    aluOutM    <= aluResultE;
    writeDataM <= writeDataE;
    wa3M       <= wa3E;
  end

endmodule

// ==== logic/hazardUnit.sv ====
`timescale 1ns/1ns

module hazardUnit import armIsaPkg::*, pipeCtrlPkg::*; (
  input  regIndex ra1D,
  input  regIndex ra2D,
  input  regIndex ra1E,
  input  regIndex ra2E,
  input  regIndex wa3E,
  input  regIndex wa3M,
  input  regIndex wa3W,
  input  logic    regWriteM,
  input  logic    regWriteW,
  input  logic    memToRegE,
  input  logic    branchTakenE,
  output fwdSel   forwardAE,
  output fwdSel   forwardBE,
  output logic    stallF,
  output logic    stallD,
  output logic    flushD,
  output logic    flushE
);

  logic ldrStall;

  // Memory stage wins, it holds the younger result
  function automatic fwdSel pickForward(regIndex ra);
    fwdSel sel;
    if (regWriteM && ra == wa3M) begin
      sel = fwdMem;
    end else if (regWriteW && ra == wa3W) begin
      sel = fwdWb;
    end else begin
      sel = fwdReg;
    end
    return sel;
  endfunction

  always_comb begin
    forwardAE = pickForward(ra1E);
    forwardBE = pickForward(ra2E);
  end

  // Load data is ready only in writeback, so hold decode one cycle
  assign ldrStall = memToRegE && (ra1D == wa3E || ra2D == wa3E);

  assign stallF = ldrStall;
  assign stallD = ldrStall;
  assign flushD = branchTakenE;
  assign flushE = ldrStall | branchTakenE;

endmodule

// ==== logic/memWriteback.sv ====
`timescale 1ns/1ns

module memWriteback import armIsaPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic [31:0] aluOutM,
  input  logic [31:0] writeDataM,
  input  regIndex     wa3M,
  input  logic        regWriteM,
  input  logic        memWriteM,
  input  logic        memToRegM,
  input  logic [31:0] readData,
  output logic [31:0] dataAddr,
  output logic [31:0] writeData,
  output logic        memWrite,
  output logic [31:0] resultW,
  output regIndex     wa3W,
  output logic        regWriteW
);

  logic [31:0] aluOutW;
  logic [31:0] readDataW;
  logic        memToRegW;

  // Data memory ports
  assign dataAddr  = aluOutM;
  assign writeData = writeDataM;
  assign memWrite  = memWriteM;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      regWriteW <= 1'b0;
      memToRegW <= 1'b0;
    end else begin
      regWriteW <= regWriteM;
      memToRegW <= memToRegM;
    end
  end

  always_ff @(posedge clk) begin
    aluOutW   <= aluOutM;
    readDataW <= readData;
    wa3W      <= wa3M;
  end

  assign resultW = memToRegW ? readDataW : aluOutW;

endmodule

// ==== logic/armCore.sv ====
`timescale 1ns/1ns

module armCore import armIsaPkg::*, pipeCtrlPkg::*; #(
  parameter logic [31:0] resetVector = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        rstN,
  input  logic [31:0] instr,
  input  logic [31:0] readData,
  output logic [31:0] pc,
  output logic [31:0] dataAddr,
  output logic [31:0] writeData,
  output logic        memWrite
);

  // Decode to execute
  condCode     condD;
  aluOp        aluOpD;
  logic        aluSrcD;
  logic        zeroAD;
  logic        setFlagsD;
  logic        regWriteD;
  logic        memWriteD;
  logic        memToRegD;
  logic        branchD;
  logic [31:0] rd1D;
  logic [31:0] rd2D;
  regIndex     ra1D;
  regIndex     ra2D;
  regIndex     wa3D;
  logic [31:0] extImmD;

  // Execute and memory stage
  logic        branchTakenE;
  logic [31:0] branchTargetE;
  regIndex     ra1E;
  regIndex     ra2E;
  regIndex     wa3E;
  logic        memToRegE;
  logic [31:0] aluOutM;
  logic [31:0] writeDataM;
  regIndex     wa3M;
  logic        regWriteM;
  logic        memWriteM;
  logic        memToRegM;

  // Writeback
  logic [31:0] resultW;
  regIndex     wa3W;
  logic        regWriteW;

  // Hazard controls
  fwdSel       forwardAE;
  fwdSel       forwardBE;
  logic        stallF;
  logic        stallD;
  logic        flushD;
  logic        flushE;

  fetchDecode #(
    .resetVector (resetVector)
  ) i_fetchDecode (
    .clk, .rstN, .stallF, .stallD, .flushD,
    .branchTakenE, .branchTargetE,
    .regWriteW, .wa3W, .resultW,
    .instr, .pc,
    .condD, .aluOpD, .aluSrcD, .zeroAD, .setFlagsD,
    .regWriteD, .memWriteD, .memToRegD, .branchD,
    .rd1D, .rd2D, .ra1D, .ra2D, .wa3D, .extImmD
  );

  executeStage i_executeStage (
    .clk, .rstN, .flushE, .forwardAE, .forwardBE,
    .condD, .aluOpD, .aluSrcD, .zeroAD, .setFlagsD,
    .regWriteD, .memWriteD, .memToRegD, .branchD,
    .rd1D, .rd2D, .ra1D, .ra2D, .wa3D, .extImmD,
    .resultW,
    .branchTakenE, .branchTargetE,
    .aluOutM, .writeDataM, .wa3M, .regWriteM, .memWriteM, .memToRegM,
    .ra1E, .ra2E, .wa3E, .memToRegE
  );

  hazardUnit i_hazardUnit (
    .ra1D, .ra2D, .ra1E, .ra2E,
    .wa3E, .wa3M, .wa3W,
    .regWriteM, .regWriteW, .memToRegE, .branchTakenE,
    .forwardAE, .forwardBE, .stallF, .stallD, .flushD, .flushE
  );

  memWriteback i_memWriteback (
    .clk, .rstN,
    .aluOutM, .writeDataM, .wa3M, .regWriteM, .memWriteM, .memToRegM,
    .readData,
    .dataAddr, .writeData, .memWrite,
    .resultW, .wa3W, .regWriteW
  );

endmodule

// ==== test/armCore_checker.sv ====
`timescale 1ns/1ns

module armCore_checker import pipeCtrlPkg::*; (
  input  logic  clk,
  input  logic  rstN,
  input  logic  stallF,
  input  logic  stallD,
  input  logic  flushD,
  input  logic  regWriteM,
  input  fwdSel forwardAE
);

  int violations = 0;

  // Fetch and decode hold together on a load-use hazard
  stallPair: assert property (@(posedge clk) disable iff (!rstN) stallF == stallD)
    else begin
      $error("stallF and stallD differ");
      violations++;
    end

  flushNoStall: assert property (@(posedge clk) disable iff (!rstN) !(flushD && stallD))
    else begin
      $error("flushD raised while decode is stalled");
      violations++;
    end

  // Memory stage result is only live with its write strobe
  memForwardLive: assert property (@(posedge clk) disable iff (!rstN)
      (forwardAE == fwdMem) |-> regWriteM)
    else begin
      $error("forwardAE selects the memory stage while regWriteM is low");
      violations++;
    end

endmodule

// ==== test/storeMonitor.sv ====
`timescale 1ns/1ns

module storeMonitor #(
  parameter int          maxStores   = 32,
  parameter int          nameBits    = 8 * 24,
  parameter logic [31:0] resetVector = 32'h0000_0000
) (
  input  logic                clk,
  input  logic                rstN,
  input  logic [31:0]         pc,
  input  logic                memWrite,
  input  logic [31:0]         dataAddr,
  input  logic [31:0]         writeData,
  input  int                  expCount,
  input  logic [31:0]         expAddr [0:maxStores-1],
  input  logic [31:0]         expData [0:maxStores-1],
  input  logic [nameBits-1:0] expName [0:maxStores-1],
  output int                  passCount,
  output int                  failCount,
  output int                  seenCount,
  output logic                allSeen
);

  int   passes       = 0;
  int   fails        = 0;
  int   seen         = 0;
  logic resetChecked = 1'b0;

  assign passCount = passes;
  assign failCount = fails;
  assign seenCount = seen;
  assign allSeen   = (expCount > 0) && (seen >= expCount);

  // Held reset puts the PC on the start address with no store pending
  task automatic checkReset(input logic [31:0] pcNow, input logic memWriteNow);
    if (pcNow !== resetVector) begin
      $display("ERROR resetState: expected pc %h, actual %h", resetVector, pcNow);
      fails++;
    end else if (memWriteNow !== 1'b0) begin
      $display("ERROR resetState: expected memWrite 0, actual %b", memWriteNow);
      fails++;
    end else begin
      $display("PASS resetState: pc %h", pcNow);
      passes++;
    end
  endtask

  // Stores must come in trace order
  task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
    if (seen >= expCount) begin
      $display("Unexpected store of %h to address %h after the last expected store",
               data, addr);
      fails++;
    end else if (addr !== expAddr[seen] || data !== expData[seen]) begin
      $display("ERROR %0s: expected %h at %h, actual %h at %h",
               expName[seen], expData[seen], expAddr[seen], data, addr);
      fails++;
      seen++;
    end else begin
      $display("PASS %0s: %h at %h", expName[seen], data, addr);
      passes++;
      seen++;
    end
  endtask

  // Memory stage outputs are settled by the falling edge
  always @(negedge clk) begin
    if (!rstN && !resetChecked) begin
      checkReset(pc, memWrite);
      resetChecked = 1'b1;
    end else if (rstN && memWrite) begin
      checkStore(dataAddr, writeData);
    end
  end

endmodule

// ==== test/armCore_tb.sv ====
`timescale 1ns/1ns

module armCore_tb;

  localparam int clkPeriod   = 100;
  localparam int resetCycles = 10;
  localparam int tailCycles  = 8;
  localparam int maxStores   = 32;
  localparam int nameBits    = 8 * 24;
  localparam logic [31:0] resetVector = 32'h0000_0000;

  logic        clk;
  logic        rstN;
  logic [31:0] instr;
  logic [31:0] readData;
  logic [31:0] pc;
  logic [31:0] dataAddr;
  logic [31:0] writeData;
  logic        memWrite;

  logic [31:0]         imem [0:127];
  logic [31:0]         dmem [0:255];
  logic [31:0]         expAddr [0:maxStores-1];
  logic [31:0]         expData [0:maxStores-1];
  logic [nameBits-1:0] expName [0:maxStores-1];
  int                  expCount;
  int                  instrCount;
  logic                traceLoaded;
  logic                loadOk;
  int                  passCount;
  int                  failCount;
  int                  seenCount;
  int                  assertFails;
  logic                allSeen;

  armCore #(
    .resetVector (resetVector)
  ) i_armCore (
    .clk, .rstN, .instr, .readData, .pc, .dataAddr, .writeData, .memWrite
  );

  storeMonitor #(
    .maxStores   (maxStores),
    .nameBits    (nameBits),
    .resetVector (resetVector)
  ) i_storeMonitor (
    .clk, .rstN, .pc, .memWrite, .dataAddr, .writeData,
    .expCount, .expAddr, .expData, .expName,
    .passCount, .failCount, .seenCount, .allSeen
  );

  bind armCore armCore_checker i_armCore_checker (
    .clk, .rstN, .stallF, .stallD, .flushD, .regWriteM, .forwardAE
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // Both memories answer in the same cycle
  assign instr    = imem[pc[8:2]];
  assign readData = dmem[dataAddr[9:2]];

  always @(posedge clk) begin
    if (memWrite) begin
      dmem[dataAddr[9:2]] <= writeData;
    end
  end

  // Fill words carry a condition code the core never executes
  task automatic fillMemories();
    for (int i = 0; i < 128; i++) begin
      imem[i] = {4'hf, 28'h5a5_0000 ^ 28'(i << 2)};
    end
    for (int i = 0; i < 256; i++) begin
      dmem[i] = 32'hd00d_0000 ^ (32'(i) << 2);
    end
  endtask

  task automatic loadTrace(output logic ok);
    int                  fd;
    int                  code;
    logic [7:0]          tag;
    logic [31:0]         addr;
    logic [31:0]         word;
    logic [nameBits-1:0] name;
    logic [8*128-1:0]    restOfLine;
    ok         = 1'b1;
    expCount   = 0;
    instrCount = 0;
    fd = $fopen("test/program_trace.txt", "r");
    if (fd == 0) begin
      ok = 1'b0;
    end else begin
      while ($fscanf(fd, "%s", tag) == 1) begin
        if (tag == "#") begin
          code = $fgets(restOfLine, fd);
        end else if (tag == "I") begin
          code = $fscanf(fd, "%h %h", addr, word);
          ok = ok && (code == 2);
          imem[addr[8:2]] = word;
          instrCount++;
        end else if (tag == "D") begin
          code = $fscanf(fd, "%h %h", addr, word);
          ok = ok && (code == 2);
          dmem[addr[9:2]] = word;
        end else if (tag == "S" && expCount < maxStores) begin
          code = $fscanf(fd, "%h %h %s", addr, word, name);
          ok = ok && (code == 3);
          expAddr[expCount] = addr;
          expData[expCount] = word;
          expName[expCount] = name;
          expCount++;
        end else begin
          ok = 1'b0;
        end
      end
      $fclose(fd);
    end
    if (expCount == 0) begin
      ok = 1'b0;
    end
  endtask

  initial begin
    rstN        = 1'b0;
    traceLoaded = 1'b0;
    fillMemories();
    loadTrace(loadOk);
    if (!loadOk) begin
      $display("Trace file is missing or malformed, no test was run");
      $display("Some tests failed");
    end else begin
      traceLoaded = 1'b1;
      repeat (resetCycles) @(negedge clk);
      rstN = 1'b1;
      while (!allSeen) begin
        @(negedge clk);
      end
      // Room for a stray store after the last expected one
      repeat (tailCycles) @(negedge clk);
      assertFails = i_armCore.i_armCore_checker.violations;
      $display("Tests: %0d passed, %0d failed, %0d assertion failures",
               passCount, failCount, assertFails);
      if (failCount == 0 && assertFails == 0) begin
        $display("All tests passed");
      end else begin
        $display("Some tests failed");
      end
    end
    $finish;
  end

  // Watchdog scaled by program length
  initial begin
    int limitNs;
    wait (traceLoaded);
    limitNs = (instrCount * 4 + 200) * clkPeriod;
    #(limitNs);
    $display("Timeout after %0d ns, only %0d of %0d expected stores arrived",
             limitNs, seenCount, expCount);
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== test/program_trace.txt ====
# Columns are kind, address, word and for S lines a test name
# Kind I is a program word, D an initial data word, S an expected store in order
# ALU ops with rotated immediates
I 00000000 e3a00c01
I 00000004 e3a010ff
I 00000008 e2812e3f
I 0000000c e5802000
I 00000010 e242302f
I 00000014 e5803004
I 00000018 e20340f0
I 0000001c e38454ff
I 00000020 e5804008
I 00000024 e580500c
# Forwarding from memory and writeback stages
I 00000028 e0816002
I 0000002c e0467001
I 00000030 e0868007
I 00000034 e5808010
# Load followed by a dependent instruction
I 00000038 e5909080
I 0000003c e289a011
I 00000040 e580a014
I 00000044 e590b084
I 00000048 e081c00b
I 0000004c e580c018
# Compare and conditional moves
I 00000050 e3a01007
I 00000054 e3510007
I 00000058 03a02022
I 0000005c 13a02033
I 00000060 e580201c
I 00000064 e3510008
I 00000068 03a03044
I 0000006c 13a03055
I 00000070 e5803020
# Taken branch skips two moves and a stray store
I 00000074 e3a04066
I 00000078 ea000002
I 0000007c e3a04077
I 00000080 e3a04099
I 00000084 e5804040
I 00000088 e5804024
I 0000008c eafffffe
D 00000180 12345678
D 00000184 0000f000
S 00000100 000004ef addRotImm
S 00000104 000004c0 subImm
S 00000108 000000c0 andImm
S 0000010c ff0000c0 orrRotImm
S 00000110 00000add fwdChain
S 00000114 12345689 loadUse
S 00000118 0000f0ff loadUseRm
S 0000011c 00000022 cmpEq
S 00000120 00000055 cmpNe
S 00000124 00000066 branchSkip

// ==== all.f ====
logic/armIsaPkg.sv
logic/pipeCtrlPkg.sv
logic/regFile.sv
logic/fetchDecode.sv
logic/executeStage.sv
logic/hazardUnit.sv
logic/memWriteback.sv
logic/armCore.sv
test/armCore_checker.sv
test/storeMonitor.sv
test/armCore_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module armCore_tb -Mdir obj_dir
./obj_dir/VarmCore_tb | tee /dev/stderr | grep -x "All tests passed" > /dev/null
